// ==== rtl/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

    // ======================================================================
    // Frame geometry
    // ======================================================================

    // Command and response frames on the CMD line are both 48 bits
    localparam int frame_width = 48;

    // CMD line CRC, polynomial x^7 + x^3 + 1
    localparam int crc7_width = 7;

    // Lowest CRC bit inside a frame, the end bit sits below it
    localparam int crc_lsb = 1;

    // Frame bits 47..8 are covered by the CRC
    localparam int payload_bits = 40;

    localparam int index_width = 6;
    localparam int arg_width   = 32;

    // ======================================================================
    // Response types
    // ======================================================================

    localparam int resp_type_width = 2;

    localparam logic [resp_type_width-1:0] resp_type_none = 2'd0;
    localparam logic [resp_type_width-1:0] resp_type_48   = 2'd1;

    // Raw view for shifting, field view for the CRC and end bit
    typedef union packed {
        logic [frame_width-1:0] raw;
        struct packed {
            logic                   start_bit;
            logic                   trans_bit;
            logic [index_width-1:0] cmd_index;
            logic [arg_width-1:0]   argument;
            logic [crc7_width-1:0]  crc;
            logic                   end_bit;
        } fields;
    } sd_frame_t;

endpackage

`default_nettype wire

// ==== rtl/sd_crc7.sv ====
`default_nettype none

module sd_crc7 (
    input  logic                          clk_fast,
    input  logic                          init_resetPulse,
    input  logic                          clear,
    input  logic                          shift_en,
    input  logic                          din,
    output logic [sd_pkg::crc7_width-1:0] crc
);
    import sd_pkg::*;

    // Taps of x^7 + x^3 + 1 below the top bit
    localparam logic [crc7_width-1:0] poly = 'h09;

    logic [crc7_width-1:0] start;
    logic                  feedback;

    // Clear restarts from zero, with shift_en the same edge takes in din too
    assign start    = clear ? '0 : crc;
    assign feedback = din ^ start[crc7_width-1];

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            crc <= '0;
        end else if (shift_en) begin
            crc <= {start[crc7_width-2:0], 1'b0} ^ (feedback ? poly : '0);
        end else if (clear) begin
            crc <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sd_cmd_tx.sv ====
`default_nettype none

module sd_cmd_tx (
    input  logic              clk_fast,
    input  logic              init_resetPulse,
    input  logic              cmd_trigger,
    input  sd_pkg::sd_frame_t cmd_data,
    output logic              cmd_out,
    output logic              cmd_oe,
    output logic              cmd_done
);
    import sd_pkg::*;

    localparam int cnt_width = $clog2(frame_width);
    // Index of the lowest frame bit that the CRC covers
    localparam int crc_stop  = crc_lsb + crc7_width;

    logic                  active_q;
    logic                  done_q;
    logic [cnt_width-1:0]  bit_cnt_q;
    sd_frame_t             shift_q;
    sd_frame_t             tail;
    logic                  load_tail;
    logic                  crc_shift;
    logic                  crc_din;
    logic [crc7_width-1:0] crc;

    // ======================================================================
    // CRC runs one bit ahead of the wire
    // ======================================================================

    // Bit 47 goes in on the trigger edge itself, so the remainder is
    // complete while bit 8 is still on the line
    assign crc_shift = cmd_trigger | (active_q & (bit_cnt_q > cnt_width'(crc_stop)));
    assign crc_din   = cmd_trigger ? cmd_data.raw[frame_width-1]
                                   : shift_q.raw[frame_width-2];

    sd_crc7 u_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (cmd_trigger),
        .shift_en        (crc_shift),
        .din             (crc_din),
        .crc             (crc)
    );

    // Frame tail with the remainder and end bit patched in
    always_comb begin
        tail                = cmd_data;
        tail.fields.crc     = crc;
        tail.fields.end_bit = 1'b1;
    end

    assign load_tail = active_q && (bit_cnt_q == cnt_width'(crc_stop));

    // ======================================================================
    // Bit counter and window
    // ======================================================================

    // bit_cnt_q is the index of the frame bit on the wire
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            active_q  <= 1'b0;
            done_q    <= 1'b0;
            bit_cnt_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (cmd_trigger) begin
                active_q  <= 1'b1;
                bit_cnt_q <= cnt_width'(frame_width - 1);
            end else if (active_q) begin
                bit_cnt_q <= bit_cnt_q - 1'b1;
                if (bit_cnt_q == '0) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (cmd_trigger) begin
            shift_q <= cmd_data;
        end else if (load_tail) begin
            // Bits 7..0 move up to the top for the last 8 bit times
            shift_q.raw <= tail.raw << payload_bits;
        end else if (active_q) begin
            shift_q.raw <= {shift_q.raw[frame_width-2:0], 1'b0};
        end
    end

    // Line idles high outside the window
    assign cmd_out  = active_q ? shift_q.raw[frame_width-1] : 1'b1;
    assign cmd_oe   = active_q;
    assign cmd_done = done_q;

endmodule

`default_nettype wire

// ==== rtl/sd_resp_rx.sv ====
`default_nettype none

module sd_resp_rx #(
    parameter int turnaround_cycles = 2
) (
    input  logic                               clk_fast,
    input  logic                               init_resetPulse,
    input  logic                               arm,
    input  logic                               abort,
    input  logic [sd_pkg::resp_type_width-1:0] resp_type,
    input  logic                               cmd_in,
    output logic                               resp_done,
    output sd_pkg::sd_frame_t                  resp_data,
    output logic                               resp_crc_err
);
    import sd_pkg::*;

    localparam int cnt_width  = $clog2(frame_width);
    localparam int crc_stop   = crc_lsb + crc7_width;
    localparam int turn_width = (turnaround_cycles > 1) ? $clog2(turnaround_cycles) : 1;
    localparam int turn_load  = (turnaround_cycles > 0) ? turnaround_cycles - 1 : 0;

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_turn   = 3'd1;
    localparam logic [2:0] st_search = 3'd2;
    localparam logic [2:0] st_shift  = 3'd3;
    localparam logic [2:0] st_check  = 3'd4;

    logic [2:0]            state_q;
    logic [turn_width-1:0] turn_cnt_q;
    logic [cnt_width-1:0]  bit_cnt_q;
    logic                  done_q;
    sd_frame_t             shift_q;
    logic                  start_seen;
    logic                  capture;
    logic                  crc_shift;
    logic                  crc_bad;
    logic [crc7_width-1:0] crc;

    // The start bit is frame bit 47 and counts toward the CRC
    assign start_seen = (state_q == st_search) && !cmd_in;
    assign capture    = start_seen || (state_q == st_shift);
    assign crc_shift  = start_seen ||
                        ((state_q == st_shift) && (bit_cnt_q >= cnt_width'(crc_stop)));

    sd_crc7 u_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (start_seen),
        .shift_en        (crc_shift),
        .din             (cmd_in),
        .crc             (crc)
    );

    assign crc_bad = (shift_q.fields.crc != crc) || !shift_q.fields.end_bit;

    // ======================================================================
    // Response FSM
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state_q    <= st_idle;
            turn_cnt_q <= '0;
            bit_cnt_q  <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (abort) begin
                // A new command drops whatever was pending
                state_q <= st_idle;
            end else begin
                case (state_q)
                    st_idle: begin
                        if (arm && (resp_type == resp_type_48)) begin
                            turn_cnt_q <= turn_width'(turn_load);
                            state_q    <= (turnaround_cycles > 0) ? st_turn : st_search;
                        end
                    end
                    st_turn: begin
                        // Ignore cmd_in until the card owns the line
                        turn_cnt_q <= turn_cnt_q - 1'b1;
                        if (turn_cnt_q == '0) begin
                            state_q <= st_search;
                        end
                    end
                    st_search: begin
                        bit_cnt_q <= cnt_width'(frame_width - 2);
                        if (!cmd_in) begin
                            state_q <= st_shift;
                        end
                    end
                    st_shift: begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                        if (bit_cnt_q == '0) begin
                            state_q <= st_check;
                        end
                    end
                    st_check: begin
                        done_q  <= 1'b1;
                        state_q <= st_idle;
                    end
                    default: begin
                        state_q <= st_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (capture) begin
            shift_q.raw <= {shift_q.raw[frame_width-2:0], cmd_in};
        end
        if ((state_q == st_check) && !abort) begin
            resp_data    <= shift_q;
            resp_crc_err <= crc_bad;
        end
    end

    assign resp_done = done_q;

endmodule

`default_nettype wire

// ==== rtl/sd_cmd_top.sv ====
`default_nettype none

module sd_cmd_top #(
    parameter int turnaround_cycles = 2
) (
    input  logic                               clk_fast,
    input  logic                               init_resetPulse,

    // Command side
    input  logic                               cmd_trigger,
    input  sd_pkg::sd_frame_t                  cmd_data,
    input  logic [sd_pkg::resp_type_width-1:0] resp_type,
    output logic                               cmd_done,

    // CMD pin, split into its three parts
    output logic                               cmd_out,
    output logic                               cmd_oe,
    input  logic                               cmd_in,

    // Response side
    output logic                               resp_done,
    output sd_pkg::sd_frame_t                  resp_data,
    output logic                               resp_crc_err
);

    // ======================================================================
    // Command serializer
    // ======================================================================

    sd_cmd_tx u_cmd_tx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .cmd_done        (cmd_done)
    );

    // ======================================================================
    // Response receiver
    // ======================================================================

    // Armed by the end of the command, a fresh trigger cancels it
    sd_resp_rx #(
        .turnaround_cycles (turnaround_cycles)
    ) u_resp_rx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .arm             (cmd_done),
        .abort           (cmd_trigger),
        .resp_type       (resp_type),
        .cmd_in          (cmd_in),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

endmodule

`default_nettype wire

// ==== bench/sd_cmd_checker.sv ====
`default_nettype none

module sd_cmd_checker (
    input logic clk_fast,
    input logic init_resetPulse,
    input logic cmd_trigger,
    input logic cmd_oe,
    input logic cmd_done,
    input logic resp_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Output enable only opens one cycle after a trigger
    oe_rise_after_trigger: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        $rose(cmd_oe) |-> $past(cmd_trigger))
        else $error("cmd_oe rose without a trigger on the previous cycle");

    cmd_done_single: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        cmd_done |=> !cmd_done)
        else $error("cmd_done stayed high for two cycles");

    // Host never drives the line while a response completes
    resp_done_not_in_tx: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        !(resp_done && cmd_oe))
        else $error("resp_done came while cmd_oe was high");

endmodule

bind sd_cmd_top sd_cmd_checker u_cmd_checker (
    .clk_fast        (clk_fast),
    .init_resetPulse (init_resetPulse),
    .cmd_trigger     (cmd_trigger),
    .cmd_oe          (cmd_oe),
    .cmd_done        (cmd_done),
    .resp_done       (resp_done)
);

`default_nettype wire

// ==== bench/sd_cmd_tb.sv ====
`default_nettype none

module sd_cmd_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import sd_pkg::*;

    localparam int          clk_period_ns   = 100;
    localparam int          reset_cycles    = 4;
    localparam logic [31:0] lfsr_seed       = 32'ha05b;
    localparam logic [31:0] lfsr_taps       = 32'h8020_0003;
    localparam int          watchdog_margin = 400;
    localparam int          row_words       = 8;
    localparam int          min_delay       = 3;

    logic                       clk_fast;
    logic                       init_resetPulse;
    logic                       cmd_trigger;
    sd_frame_t                  cmd_data;
    logic [resp_type_width-1:0] resp_type;
    logic                       cmd_in;
    logic                       cmd_out;
    logic                       cmd_oe;
    logic                       cmd_done;
    logic                       resp_done;
    sd_frame_t                  resp_data;
    logic                       resp_crc_err;

    logic [frame_width-1:0] stim_mem [0:255];
    int                     num_tests;
    logic                   stim_loaded = 1'b0;
    logic                   run_passed  = 1'b0;
    logic                   fail_shown  = 1'b0;
    logic [31:0]            lfsr_q;

    sd_cmd_top #(
        .turnaround_cycles (2)
    ) u_sd_cmd_top (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .resp_type       (resp_type),
        .cmd_done        (cmd_done),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .cmd_in          (cmd_in),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

    // ======================================================================
    // Checks and helpers
    // ======================================================================

    task automatic fail_run(input string msg);
        fail_shown = 1'b1;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_frame(input string name, input sd_frame_t got, input sd_frame_t exp);
        if (got.raw !== exp.raw) begin
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = (state >> 1) ^ (state[0] ? lfsr_taps : 32'h0);
    endfunction

    // Card delay of 3 to 18 cycles from four LFSR bits
    task automatic pick_delay(output int delay);
        logic [3:0] pick;
        pick = '0;
        repeat (4) begin
            pick   = {pick[2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        delay = min_delay + int'(pick);
    endtask

    task automatic load_row(input int idx, output sd_frame_t cmd,
                            output logic [resp_type_width-1:0] rtype,
                            output sd_frame_t wire_exp, output sd_frame_t resp,
                            output logic err);
        int base;
        base     = 1 + idx * row_words;
        cmd.raw  = stim_mem[8'(base)];
        rtype    = stim_mem[8'(base + 1)][resp_type_width-1:0];
        resp.raw = {stim_mem[8'(base + 2)][payload_bits-1:0], 8'h00};
        // Corruption flips the lowest CRC bit or clears the end bit
        resp.fields.crc     = stim_mem[8'(base + 3)][crc7_width-1:0]
                              ^ {6'd0, stim_mem[8'(base + 4)][0]};
        resp.fields.end_bit = ~stim_mem[8'(base + 5)][0];
        wire_exp.raw        = stim_mem[8'(base + 6)];
        err                 = stim_mem[8'(base + 7)][0];
    endtask

    // Trigger, then collect the 48 bit window and the cmd_done pulse
    task automatic send_command(input sd_frame_t cmd, input logic [resp_type_width-1:0] rtype,
                                input sd_frame_t wire_exp);
        sd_frame_t seen;
        seen.raw = '0;
        cmd_data    <= cmd;
        resp_type   <= rtype;
        cmd_trigger <= 1'b1;
        @(posedge clk_fast);
        cmd_trigger <= 1'b0;
        check_flag("cmd_oe", cmd_oe, 1'b0);
        for (int i = 0; i < frame_width; i++) begin
            @(posedge clk_fast);
            check_flag("cmd_oe", cmd_oe, 1'b1);
            check_flag("cmd_done", cmd_done, 1'b0);
            seen.raw = {seen.raw[frame_width-2:0], cmd_out};
        end
        @(posedge clk_fast);
        check_flag("cmd_oe", cmd_oe, 1'b0);
        check_flag("cmd_done", cmd_done, 1'b1);
        check_frame("cmd_out frame", seen, wire_exp);
    endtask

    task automatic drive_response(input sd_frame_t frame);
        sd_frame_t bits;
        bits = frame;
        for (int i = 0; i < frame_width; i++) begin
            cmd_in   <= bits.raw[frame_width-1];
            bits.raw = bits.raw << 1;
            @(posedge clk_fast);
        end
        cmd_in <= 1'b1;
    endtask

    task automatic wait_resp_done();
        @(posedge clk_fast);
        while (!resp_done) begin
            @(posedge clk_fast);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk_fast);
            check_flag("resp_done", resp_done, 1'b0);
            check_flag("cmd_done", cmd_done, 1'b0);
        end
    endtask

    task automatic run_test(input int idx);
        sd_frame_t                  cmd;
        sd_frame_t                  wire_exp;
        sd_frame_t                  resp;
        logic [resp_type_width-1:0] rtype;
        logic                       err;
        int                         delay;
        load_row(idx, cmd, rtype, wire_exp, resp, err);
        send_command(cmd, rtype, wire_exp);
        pick_delay(delay);
        if (rtype == resp_type_48) begin
            repeat (delay) @(posedge clk_fast);
            drive_response(resp);
            wait_resp_done();
            check_frame("resp_data", resp_data, resp);
            check_flag("resp_crc_err", resp_crc_err, err);
        end else begin
            // Unrequested answer from the card that the receiver must ignore
            expect_quiet(delay);
            drive_response(resp);
            expect_quiet(8);
        end
    endtask

    // Second trigger lands in the turnaround while the card answers anyway
    task automatic abort_in_turnaround();
        sd_frame_t                  cmd_a;
        sd_frame_t                  wire_a;
        sd_frame_t                  resp_a;
        sd_frame_t                  cmd_b;
        sd_frame_t                  wire_b;
        sd_frame_t                  resp_b;
        logic [resp_type_width-1:0] rtype;
        logic                       err;
        load_row(1, cmd_a, rtype, wire_a, resp_a, err);
        load_row(0, cmd_b, rtype, wire_b, resp_b, err);
        send_command(cmd_a, resp_type_48, wire_a);
        fork
            send_command(cmd_b, resp_type_none, wire_b);
            drive_response(resp_a);
        join
        expect_quiet(60);
    endtask

    // ======================================================================
    // Clock, main sequence and watchdog
    // ======================================================================

    initial begin
        clk_fast = 1'b0;
        forever #(clk_period_ns / 2) clk_fast = ~clk_fast;
    end

    initial begin
        init_resetPulse <= 1'b1;
        cmd_trigger     <= 1'b0;
        cmd_data        <= '0;
        resp_type       <= resp_type_none;
        cmd_in          <= 1'b1;
        lfsr_q          = lfsr_seed;
        $readmemh("bench/sd_stimulus.hex", stim_mem);
        num_tests = int'(stim_mem[0][7:0]);
        if (num_tests < 2 || num_tests > 31) begin
            fail_run("Stimulus file holds an unusable test count");
        end
        stim_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk_fast);
        init_resetPulse <= 1'b0;
        repeat (8) begin
            @(posedge clk_fast);
            check_flag("cmd_oe", cmd_oe, 1'b0);
            check_flag("cmd_done", cmd_done, 1'b0);
            check_flag("resp_done", resp_done, 1'b0);
        end
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        abort_in_turnaround();
        run_passed = 1'b1;
        $display("All tests passed!");
        $finish;
    end

    // Each test takes at most two frames plus the card delay
    initial begin
        int limit;
        wait (stim_loaded);
        limit = num_tests * (48 + 48 + 40) + watchdog_margin;
        repeat (limit) @(posedge clk_fast);
        fail_run("Timeout: the tests did not finish in the expected number of cycles");
    end

    final begin
        if (!run_passed && !fail_shown) begin
            $display("Run stopped before the last test, an assertion failed");
            $display("Test failures found");
        end
    end

endmodule

`default_nettype wire

// ==== bench/sd_stimulus.hex ====
// First word is the test count. Then per test: command, resp type, resp payload, resp crc7,
// corrupt crc, corrupt end bit, expected wire frame, expected crc error
a
4000000000ab 0 0000000000 00 0 0 400000000095 0
48000001aa00 1 08000001aa 09 0 0 48000001aa87 0
770000000000 1 0d00000000 4c 0 0 770000000065 0
6940000000ff 1 0040000000 49 0 0 694000000077 0
510000000000 1 1100000900 33 0 0 510000000055 0
510000000012 1 1100000900 33 1 0 510000000055 1
7a0000000000 1 1e00000000 40 0 1 7a00000000fd 1
41000000005a 1 0100000000 36 0 0 4100000000f9 0
690000000000 0 0000000000 00 0 0 6900000000e5 0
400000000000 1 0000000000 00 1 1 400000000095 1

// ==== flist.f ====
rtl/sd_pkg.sv
rtl/sd_crc7.sv
rtl/sd_cmd_tx.sv
rtl/sd_resp_rx.sv
rtl/sd_cmd_top.sv
bench/sd_cmd_checker.sv
bench/sd_cmd_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= sd_cmd_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
